// File: common/ntm_data_pkg.sv
//////////////////////////////
// Data widths for the engine
// Operand, index and Wishbone vector types
//////////////////////////////

`default_nettype none

package ntm_data_pkg;

  //////////////////////////////
  // Widths

  // Operand and modulus width
  localparam int DATA_W = 16;
  // Loop bound and loop index width
  localparam int INDEX_W = 8;
  // Register word address width
  localparam int WB_ADR_W = 3;

  //////////////////////////////
  // Vector types

  // Operand, modulus or product
  typedef logic [DATA_W-1:0] data_t;
  // Loop bound or loop index
  typedef logic [INDEX_W-1:0] index_t;
  // Register word address
  typedef logic [WB_ADR_W-1:0] wb_adr_t;
  // Bus word, same width as the operands
  typedef logic [DATA_W-1:0] wb_dat_t;

endpackage

`default_nettype wire

// File: common/ntm_ctrl_pkg.sv
//////////////////////////////
// Controller state encoding
// Wishbone register map
//////////////////////////////

`default_nettype none

package ntm_ctrl_pkg;

  //////////////////////////////
  // Controller FSM

  // IDLE waits for start, INPUT accepts a pair,
  // MULTIPLY waits on the multiplier, OUTPUT decides next element
  typedef enum logic [2:0] {
    IDLE,
    INPUT,
    MULTIPLY,
    OUTPUT,
    DONE
  } ctrl_state_t;

  //////////////////////////////
  // Register map, word addresses

  localparam ntm_data_pkg::wb_adr_t REG_MODULO  = 3'd0;
  localparam ntm_data_pkg::wb_adr_t REG_SIZE_I  = 3'd1;
  localparam ntm_data_pkg::wb_adr_t REG_SIZE_J  = 3'd2;
  localparam ntm_data_pkg::wb_adr_t REG_LENGTH  = 3'd3;
  // Bit 0 starts a run, reads back as zero
  localparam ntm_data_pkg::wb_adr_t REG_CONTROL = 3'd4;
  // Bit 0 busy, bit 1 done
  localparam ntm_data_pkg::wb_adr_t REG_STATUS  = 3'd5;

endpackage

`default_nettype wire

// File: hw/ntm_wb_regs.sv
//////////////////////////////
// Wishbone classic slave
// Configuration registers, start pulse, status
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ntm_wb_regs (
  input  wire                      CLK,
  input  wire                      RST,
  input  wire                      wb_cyc,
  input  wire                      wb_stb,
  input  wire                      wb_we,
  input  wire ntm_data_pkg::wb_adr_t wb_adr,
  input  wire ntm_data_pkg::wb_dat_t wb_dat_w,
  output ntm_data_pkg::wb_dat_t    wb_dat_r,
  output logic                     wb_ack,
  output ntm_data_pkg::data_t      modulo,
  output ntm_data_pkg::index_t     size_i,
  output ntm_data_pkg::index_t     size_j,
  output ntm_data_pkg::index_t     length,
  output logic                     start,
  input  wire                      busy,
  input  wire                      done
);

  import ntm_data_pkg::*;
  import ntm_ctrl_pkg::*;

  // Set after ack until the host lets go of stb
  logic    stb_hold;
  // New request this cycle
  logic    access;
  wb_dat_t rd_data;

  assign access = wb_cyc && wb_stb && !wb_ack && !stb_hold;

  // Read mux, unmapped and control read as zero
  always_comb begin
    case (wb_adr)
      REG_MODULO: rd_data = modulo;
      REG_SIZE_I: rd_data = wb_dat_t'(size_i);
      REG_SIZE_J: rd_data = wb_dat_t'(size_j);
      REG_LENGTH: rd_data = wb_dat_t'(length);
      REG_STATUS: rd_data = wb_dat_t'({done, busy});
      default:    rd_data = '0;
    endcase
  end

  //////////////////////////////
  // Bus side registers

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wb_ack   <= 1'b0;
      stb_hold <= 1'b0;
      start    <= 1'b0;
      wb_dat_r <= '0;
      modulo   <= '0;
      size_i   <= '0;
      size_j   <= '0;
      length   <= '0;
    end else begin
      // Single cycle ack
      wb_ack <= access;
      start  <= 1'b0;
      if (wb_ack) begin
        stb_hold <= 1'b1;
      end else if (!wb_stb) begin
        stb_hold <= 1'b0;
      end
      if (access && wb_we) begin
        case (wb_adr)
          REG_MODULO:  modulo <= wb_dat_w;
          REG_SIZE_I:  size_i <= wb_dat_w[INDEX_W-1:0];
          REG_SIZE_J:  size_j <= wb_dat_w[INDEX_W-1:0];
          REG_LENGTH:  length <= wb_dat_w[INDEX_W-1:0];
          // Ignored while a run is active
          REG_CONTROL: start  <= wb_dat_w[0] && !busy;
          default:     ;
        endcase
      end
      if (access && !wb_we) begin
        wb_dat_r <= rd_data;
      end
    end
  end

endmodule

`default_nettype wire

// File: matrix_mult/matrix_mult_ctrl.sv
//////////////////////////////
// Engine controller FSM
// Operand latch, multiplier start, result and flags
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module matrix_mult_ctrl (
  input  wire                    CLK,
  input  wire                    RST,
  input  wire                    start,
  // Operand stream
  input  wire                    in_valid,
  output logic                   in_ready,
  input  wire ntm_data_pkg::data_t in_a,
  input  wire ntm_data_pkg::data_t in_b,
  // Multiplier side
  output logic                   mul_start,
  output ntm_data_pkg::data_t    mul_a,
  output ntm_data_pkg::data_t    mul_b,
  input  wire                    mul_done,
  input  wire ntm_data_pkg::data_t mul_result,
  // Index counter side
  output logic                   cnt_clear,
  output logic                   cnt_step,
  input  wire                    scalar_wrap,
  input  wire                    vector_wrap,
  input  wire                    matrix_wrap,
  // Result stream and status
  output logic                   out_valid,
  output ntm_data_pkg::data_t    out_data,
  output logic                   out_scalar_end,
  output logic                   out_vector_end,
  output logic                   out_matrix_end,
  output logic                   busy,
  output logic                   done
);

  import ntm_ctrl_pkg::*;

  ctrl_state_t state;

  // Strobes decoded from the current state
  assign in_ready  = (state == INPUT);
  assign busy      = (state != IDLE);
  // Counter clears on the edge that enters INPUT
  assign cnt_clear = (state == IDLE) && start;
  // Advance indices only when another element follows
  assign cnt_step  = (state == OUTPUT) && !matrix_wrap;

  //////////////////////////////
  // State and control outputs

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= IDLE;
      mul_start      <= 1'b0;
      out_valid      <= 1'b0;
      out_scalar_end <= 1'b0;
      out_vector_end <= 1'b0;
      out_matrix_end <= 1'b0;
      done           <= 1'b0;
    end else begin
      // One cycle pulses by default
      mul_start      <= 1'b0;
      out_valid      <= 1'b0;
      out_scalar_end <= 1'b0;
      out_vector_end <= 1'b0;
      out_matrix_end <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            // Done stays sticky until here
            done  <= 1'b0;
            state <= INPUT;
          end
        end
        INPUT: begin
          if (in_valid) begin
            mul_start <= 1'b1;
            state     <= MULTIPLY;
          end
        end
        MULTIPLY: begin
          if (mul_done) begin
            // Flags reflect the element just finished
            out_valid      <= 1'b1;
            out_scalar_end <= scalar_wrap;
            out_vector_end <= vector_wrap;
            out_matrix_end <= matrix_wrap;
            state          <= OUTPUT;
          end
        end
        OUTPUT: begin
          state <= matrix_wrap ? DONE : INPUT;
        end
        DONE: begin
          done  <= 1'b1;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Operand and result payload

  always_ff @(posedge CLK) begin
    // Latch pair on transfer
    if (in_ready && in_valid) begin
      mul_a <= in_a;
      mul_b <= in_b;
    end
    if ((state == MULTIPLY) && mul_done) begin
      out_data <= mul_result;
    end
  end

endmodule

`default_nettype wire

// File: matrix_mult/index_counter.sv
//////////////////////////////
// Nested loop index counter
// Scalar, vector and matrix wrap flags
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module index_counter (
  input  wire                     CLK,
  input  wire                     RST,
  input  wire                     clear,
  input  wire                     step,
  input  wire ntm_data_pkg::index_t size_i,
  input  wire ntm_data_pkg::index_t size_j,
  input  wire ntm_data_pkg::index_t length,
  output logic                    scalar_wrap,
  output logic                    vector_wrap,
  output logic                    matrix_wrap
);

  import ntm_data_pkg::*;

  // Matrix, vector and scalar indices, outer to inner
  index_t idx_i;
  index_t idx_j;
  index_t idx_k;
  // Last valid index per loop
  index_t last_i;
  index_t last_j;
  index_t last_k;

  // Zero bound behaves as one
  assign last_i = (size_i == '0) ? '0 : size_i - 1'b1;
  assign last_j = (size_j == '0) ? '0 : size_j - 1'b1;
  assign last_k = (length == '0) ? '0 : length - 1'b1;

  // Outer flags include the inner ones
  assign scalar_wrap = (idx_k == last_k);
  assign vector_wrap = scalar_wrap && (idx_j == last_j);
  assign matrix_wrap = vector_wrap && (idx_i == last_i);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      idx_i <= '0;
      idx_j <= '0;
      idx_k <= '0;
    end else if (clear) begin
      idx_i <= '0;
      idx_j <= '0;
      idx_k <= '0;
    end else if (step) begin
      if (!scalar_wrap) begin
        idx_k <= idx_k + 1'b1;
      end else begin
        // Scalar loop done, carry outward
        idx_k <= '0;
        if (!vector_wrap) begin
          idx_j <= idx_j + 1'b1;
        end else begin
          idx_j <= '0;
          idx_i <= matrix_wrap ? '0 : idx_i + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: matrix_mult/modular_multiplier.sv
//////////////////////////////
// Sequential modular multiplier
// MSB first double and add, one bit per cycle
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module modular_multiplier (
  input  wire                    CLK,
  input  wire                    RST,
  input  wire                    start,
  input  wire ntm_data_pkg::data_t a,
  input  wire ntm_data_pkg::data_t b,
  input  wire ntm_data_pkg::data_t modulo,
  output logic                   done,
  output ntm_data_pkg::data_t    result
);

  import ntm_data_pkg::*;

  typedef logic [$clog2(DATA_W)-1:0] bit_cnt_t;

  // Operands held for the whole product
  data_t    a_q;
  data_t    b_q;
  data_t    m_q;
  // Partial product, always below the modulus
  data_t    acc;
  logic     running;
  bit_cnt_t bits_left;

  // One step, acc = (2*acc + bit*a) mod m
  // Both terms below m, so each reduction needs at most one subtract
  function automatic data_t mod_step(data_t acc_in, logic bit_in, data_t a_in, data_t m_in);
    logic [DATA_W:0] dbl;
    logic [DATA_W:0] sum;
    dbl = {acc_in, 1'b0};
    if (dbl >= {1'b0, m_in}) dbl = dbl - {1'b0, m_in};
    sum = dbl + (bit_in ? {1'b0, a_in} : '0);
    if (sum >= {1'b0, m_in}) sum = sum - {1'b0, m_in};
    return sum[DATA_W-1:0];
  endfunction

  //////////////////////////////
  // Sequencing

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      running   <= 1'b0;
      bits_left <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        // MSB handled on the start edge
        running   <= 1'b1;
        bits_left <= bit_cnt_t'(DATA_W - 1);
      end else if (running) begin
        if (bits_left == '0) begin
          running <= 1'b0;
          done    <= 1'b1;
        end else begin
          bits_left <= bits_left - 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (start) begin
      a_q <= a;
      m_q <= modulo;
      b_q <= b << 1;
      acc <= mod_step('0, b[DATA_W-1], a, modulo);
    end else if (running) begin
      if (bits_left == '0) begin
        result <= acc;
      end else begin
        acc <= mod_step(acc, b_q[DATA_W-1], a_q, m_q);
        b_q <= b_q << 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/ntm_matrix_mult_top.sv
//////////////////////////////
// Element-wise modular multiply engine
// Registers, controller, counter, multiplier
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ntm_matrix_mult_top (
  input  wire                      CLK,
  input  wire                      RST,
  // Wishbone slave
  input  wire                      wb_cyc,
  input  wire                      wb_stb,
  input  wire                      wb_we,
  input  wire ntm_data_pkg::wb_adr_t wb_adr,
  input  wire ntm_data_pkg::wb_dat_t wb_dat_w,
  output ntm_data_pkg::wb_dat_t    wb_dat_r,
  output logic                     wb_ack,
  // Operand stream
  input  wire                      in_valid,
  output logic                     in_ready,
  input  wire ntm_data_pkg::data_t   in_a,
  input  wire ntm_data_pkg::data_t   in_b,
  // Result stream
  output logic                     out_valid,
  output ntm_data_pkg::data_t      out_data,
  output logic                     out_scalar_end,
  output logic                     out_vector_end,
  output logic                     out_matrix_end
);

  import ntm_data_pkg::*;

  // Configuration and status
  data_t  modulo;
  index_t size_i;
  index_t size_j;
  index_t length;
  logic   start;
  logic   busy;
  logic   done;
  // Multiplier handshake
  logic   mul_start;
  data_t  mul_a;
  data_t  mul_b;
  logic   mul_done;
  data_t  mul_result;
  // Loop counter
  logic   cnt_clear;
  logic   cnt_step;
  logic   scalar_wrap;
  logic   vector_wrap;
  logic   matrix_wrap;

  ntm_wb_regs ntm_wb_regs_i (
    .CLK(CLK), .RST(RST),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .modulo(modulo), .size_i(size_i), .size_j(size_j), .length(length),
    .start(start), .busy(busy), .done(done)
  );

  matrix_mult_ctrl matrix_mult_ctrl_i (
    .CLK(CLK), .RST(RST), .start(start),
    .in_valid(in_valid), .in_ready(in_ready), .in_a(in_a), .in_b(in_b),
    .mul_start(mul_start), .mul_a(mul_a), .mul_b(mul_b),
    .mul_done(mul_done), .mul_result(mul_result),
    .cnt_clear(cnt_clear), .cnt_step(cnt_step),
    .scalar_wrap(scalar_wrap), .vector_wrap(vector_wrap), .matrix_wrap(matrix_wrap),
    .out_valid(out_valid), .out_data(out_data), .out_scalar_end(out_scalar_end),
    .out_vector_end(out_vector_end), .out_matrix_end(out_matrix_end),
    .busy(busy), .done(done)
  );

  index_counter index_counter_i (
    .CLK(CLK), .RST(RST), .clear(cnt_clear), .step(cnt_step),
    .size_i(size_i), .size_j(size_j), .length(length),
    .scalar_wrap(scalar_wrap), .vector_wrap(vector_wrap), .matrix_wrap(matrix_wrap)
  );

  modular_multiplier modular_multiplier_i (
    .CLK(CLK), .RST(RST), .start(mul_start),
    .a(mul_a), .b(mul_b), .modulo(modulo),
    .done(mul_done), .result(mul_result)
  );

endmodule

`default_nettype wire

// File: bench/ntm_matrix_mult_chk.sv
//////////////////////////////
// Bound assertions for the engine top
// Pulse widths, idle ready, flag nesting, reset
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ntm_matrix_mult_chk (
  input wire CLK,
  input wire RST,
  input wire wb_ack,
  input wire in_ready,
  input wire out_valid,
  input wire busy,
  input wire out_scalar_end,
  input wire out_vector_end,
  input wire out_matrix_end
);

  // Ack and result are single cycle pulses
  ack_pulse: assert property (@(posedge CLK) disable iff (RST) wb_ack |=> !wb_ack)
    else $error("wb_ack high on two consecutive cycles");
  out_pulse: assert property (@(posedge CLK) disable iff (RST) out_valid |=> !out_valid)
    else $error("out_valid high on two consecutive cycles");

  // No operand accepted while idle
  idle_ready: assert property (@(posedge CLK) disable iff (RST) !busy |-> !in_ready)
    else $error("in_ready high while not busy");

  // Outer boundary includes the inner ones
  flag_nest: assert property (@(posedge CLK) disable iff (RST)
    out_matrix_end |-> (out_vector_end && out_scalar_end))
    else $error("matrix end without vector and scalar end");

  reset_state: assert property (@(posedge CLK) RST |=> (!wb_ack && !in_ready && !out_valid))
    else $error("handshake outputs not cleared by reset");

endmodule

bind ntm_matrix_mult_top ntm_matrix_mult_chk ntm_matrix_mult_chk_i (
  .CLK(CLK), .RST(RST), .wb_ack(wb_ack), .in_ready(in_ready), .out_valid(out_valid),
  .busy(busy), .out_scalar_end(out_scalar_end), .out_vector_end(out_vector_end),
  .out_matrix_end(out_matrix_end)
);

`default_nettype wire

// File: bench/tb_ntm_matrix_mult.sv
//////////////////////////////
// Testbench for the modular multiply engine
// Wishbone and stream tasks, test table
// Compare tasks and run summary
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_ntm_matrix_mult;

  import ntm_data_pkg::*;
  import ntm_ctrl_pkg::*;

  localparam int NUM_TESTS = 7;
  // Bound on every wait loop in clock cycles
  localparam int WAIT_LIMIT = 200;
  // Transfer edge to result edge
  localparam int LATENCY = 19;

  // Test row with its expected result count
  typedef struct {
    string  name;
    data_t  modulo;
    index_t size_i;
    index_t size_j;
    index_t length;
    bit     stall;
    bit     rewrite;
    int     n_out;
  } test_row_t;

  logic    CLK;
  logic    RST;
  logic    wb_cyc;
  logic    wb_stb;
  logic    wb_we;
  wb_adr_t wb_adr;
  wb_dat_t wb_dat_w;
  wb_dat_t wb_dat_r;
  logic    wb_ack;
  logic    in_valid;
  logic    in_ready;
  data_t   in_a;
  data_t   in_b;
  logic    out_valid;
  data_t   out_data;
  logic    out_scalar_end;
  logic    out_vector_end;
  logic    out_matrix_end;

  test_row_t tests [NUM_TESTS];
  int        error_count;
  int        tests_run;
  // Set by a timeout to stop further tests
  bit        abort;
  // Rising edges since reset
  int        cycle;
  // Result pulses seen since reset
  int        out_count;

  ntm_matrix_mult_top ntm_matrix_mult_top_i (
    .CLK(CLK), .RST(RST),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .in_valid(in_valid), .in_ready(in_ready), .in_a(in_a), .in_b(in_b),
    .out_valid(out_valid), .out_data(out_data), .out_scalar_end(out_scalar_end),
    .out_vector_end(out_vector_end), .out_matrix_end(out_matrix_end)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK or posedge RST) begin
    if (RST) cycle <= 0;
    else cycle <= cycle + 1;
  end

  // Every result pulse is counted
  always @(negedge CLK) begin
    if (RST) out_count = 0;
    else if (out_valid) out_count = out_count + 1;
  end

  //////////////////////////////
  // Compare tasks

  task automatic check_data(string what, data_t exp, data_t act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %h actual %h", what, exp, act);
      error_count++;
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %b actual %b", what, exp, act);
      error_count++;
    end
  endtask

  task automatic check_word(string what, wb_dat_t exp, wb_dat_t act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %h actual %h", what, exp, act);
      error_count++;
    end
  endtask

  // Cycle counts and result counts
  task automatic check_count(string what, int exp, int act);
    if (exp != act) begin
      $display("MISMATCH %s expected %0d actual %0d", what, exp, act);
      error_count++;
    end
  endtask

  task automatic report_timeout(string what);
    $display("Timeout: no %s within %0d cycles", what, WAIT_LIMIT);
    error_count++;
    abort = 1'b1;
  endtask

  //////////////////////////////
  // Reference model

  function automatic data_t mod_product(data_t a, data_t b, data_t m);
    logic [63:0] prod;
    prod = 64'(a) * 64'(b);
    return data_t'(prod % 64'(m));
  endfunction

  // Zero bound counts as one
  function automatic int loop_bound(index_t b);
    return (b == '0) ? 1 : int'(b);
  endfunction

  //////////////////////////////
  // Bus and stream tasks

  task automatic wb_access(logic we, wb_adr_t adr, wb_dat_t wdat, output wb_dat_t rdat);
    int t;
    @(posedge CLK);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    for (t = 0; t < WAIT_LIMIT; t++) begin
      @(negedge CLK);
      if (wb_ack) break;
    end
    if (t == WAIT_LIMIT) report_timeout("Wishbone ack");
    // Read data registered with ack
    rdat = wb_dat_r;
    @(posedge CLK);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(wb_adr_t adr, wb_dat_t wdat);
    wb_dat_t unused;
    wb_access(1'b1, adr, wdat, unused);
  endtask

  task automatic wb_read(wb_adr_t adr, output wb_dat_t rdat);
    wb_access(1'b0, adr, '0, rdat);
  endtask

  // Poll status until busy clears
  task automatic wait_idle(output wb_dat_t status);
    int t;
    for (t = 0; t < WAIT_LIMIT; t++) begin
      wb_read(REG_STATUS, status);
      if (!status[0]) break;
    end
    if (t == WAIT_LIMIT) report_timeout("return to idle");
  endtask

  // Holds the pair until in_ready
  // Returns the cycle count just before the transfer edge
  task automatic send_pair(data_t a, data_t b, int gap, output int xfer_cycle);
    int t;
    repeat (gap) begin
      @(posedge CLK);
      #1;
    end
    in_valid = 1'b1;
    in_a     = a;
    in_b     = b;
    for (t = 0; t < WAIT_LIMIT; t++) begin
      @(negedge CLK);
      if (in_ready) break;
    end
    if (t == WAIT_LIMIT) report_timeout("in_ready");
    xfer_cycle = cycle;
    @(posedge CLK);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic recv_result(output data_t data, output logic s_end, output logic v_end,
                             output logic m_end, output int out_cycle);
    int t;
    for (t = 0; t < WAIT_LIMIT; t++) begin
      @(negedge CLK);
      if (out_valid) break;
    end
    if (t == WAIT_LIMIT) report_timeout("out_valid");
    data      = out_data;
    s_end     = out_scalar_end;
    v_end     = out_vector_end;
    m_end     = out_matrix_end;
    out_cycle = cycle;
    @(posedge CLK);
    #1;
  endtask

  //////////////////////////////
  // Tests

  task automatic check_register_map();
    int      errors_before;
    wb_dat_t rd;
    errors_before = error_count;
    wb_read(3'd6, rd);
    check_word("unmapped 6", '0, rd);
    wb_read(3'd7, rd);
    check_word("unmapped 7", '0, rd);
    wb_read(REG_CONTROL, rd);
    check_word("control read", '0, rd);
    wb_read(REG_STATUS, rd);
    check_word("status after reset", '0, rd);
    $display("test %-16s %0s", "register_map",
             (error_count == errors_before) ? "ok" : "errors");
  endtask

  task automatic run_test(test_row_t row);
    int      errors_before;
    int      outs_before;
    int      n_i;
    int      n_j;
    int      n_k;
    int      e;
    int      xfer_cycle;
    int      out_cycle;
    logic    last_k;
    logic    last_j;
    logic    last_i;
    data_t   a;
    data_t   b;
    data_t   data;
    logic    s_end;
    logic    v_end;
    logic    m_end;
    wb_dat_t rd;
    string   tag;
    errors_before = error_count;
    n_i = loop_bound(row.size_i);
    n_j = loop_bound(row.size_j);
    n_k = loop_bound(row.length);
    wb_write(REG_MODULO, row.modulo);
    wb_write(REG_SIZE_I, wb_dat_t'(row.size_i));
    wb_write(REG_SIZE_J, wb_dat_t'(row.size_j));
    wb_write(REG_LENGTH, wb_dat_t'(row.length));
    wb_read(REG_MODULO, rd);
    check_word({row.name, " modulo"}, row.modulo, rd);
    wb_read(REG_SIZE_I, rd);
    check_word({row.name, " size_i"}, wb_dat_t'(row.size_i), rd);
    wb_read(REG_SIZE_J, rd);
    check_word({row.name, " size_j"}, wb_dat_t'(row.size_j), rd);
    wb_read(REG_LENGTH, rd);
    check_word({row.name, " length"}, wb_dat_t'(row.length), rd);
    outs_before = out_count;
    wb_write(REG_CONTROL, 16'h0001);
    for (e = 0; e < row.n_out && !abort; e++) begin
      // First pair is the largest legal operand
      if (e == 0) begin
        a = row.modulo - 1'b1;
        b = a;
      end else begin
        a = data_t'($urandom % row.modulo);
        b = data_t'($urandom % row.modulo);
      end
      send_pair(a, b, row.stall ? int'($urandom % 4) : 0, xfer_cycle);
      if (abort) break;
      recv_result(data, s_end, v_end, m_end, out_cycle);
      if (abort) break;
      // Loop position with the scalar index innermost
      last_k = ((e % n_k) == n_k - 1);
      last_j = (((e / n_k) % n_j) == n_j - 1);
      last_i = ((e / (n_k * n_j)) == n_i - 1);
      tag = $sformatf("%s[%0d]", row.name, e);
      check_data({tag, " data"}, mod_product(a, b, row.modulo), data);
      check_flag({tag, " scalar_end"}, last_k, s_end);
      check_flag({tag, " vector_end"}, last_k && last_j, v_end);
      check_flag({tag, " matrix_end"}, last_k && last_j && last_i, m_end);
      check_count({tag, " latency"}, LATENCY, out_cycle - xfer_cycle);
      // Second start while busy must be ignored
      if (row.rewrite && e == 0) begin
        wb_write(REG_CONTROL, 16'h0001);
        wb_read(REG_STATUS, rd);
        check_word({tag, " status busy"}, 16'h0001, rd);
      end
    end
    if (!abort) begin
      wait_idle(rd);
      check_word({row.name, " status done"}, 16'h0002, rd);
      check_count({row.name, " results"}, row.n_out, out_count - outs_before);
    end
    tests_run++;
    $display("test %-16s %0d results, %0s", row.name, out_count - outs_before,
             (error_count == errors_before) ? "ok" : "errors");
  endtask

  // name, modulo, size_i, size_j, length, stall, rewrite, results
  task automatic load_tests();
    tests[0] = '{"single", 16'd97, 8'd1, 8'd1, 8'd1, 1'b0, 1'b0, 1};
    tests[1] = '{"nested", 16'd251, 8'd2, 8'd3, 8'd2, 1'b0, 1'b0, 12};
    tests[2] = '{"small_prime", 16'd13, 8'd1, 8'd2, 8'd3, 1'b0, 1'b0, 6};
    tests[3] = '{"mod_65521", 16'd65521, 8'd2, 8'd2, 8'd2, 1'b0, 1'b0, 8};
    tests[4] = '{"zero_bounds", 16'd7, 8'd0, 8'd2, 8'd0, 1'b0, 1'b0, 2};
    tests[5] = '{"stalls", 16'd1009, 8'd2, 8'd3, 8'd2, 1'b1, 1'b0, 12};
    tests[6] = '{"control_ignored", 16'd65521, 8'd1, 8'd3, 8'd2, 1'b1, 1'b1, 6};
  endtask

  //////////////////////////////
  // Main sequence

  initial begin
    int t;
    void'($urandom(30));
    RST         = 1'b1;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    in_valid    = 1'b0;
    in_a        = '0;
    in_b        = '0;
    error_count = 0;
    tests_run   = 0;
    abort       = 1'b0;
    load_tests();
    repeat (10) @(posedge CLK);
    #1;
    RST = 1'b0;
    check_register_map();
    for (t = 0; t < NUM_TESTS && !abort; t++) begin
      run_test(tests[t]);
    end
    $display("Summary: %0d tests, %0d results, %0d errors", tests_run, out_count,
             error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
common/ntm_data_pkg.sv
common/ntm_ctrl_pkg.sv
hw/ntm_wb_regs.sv
matrix_mult/matrix_mult_ctrl.sv
matrix_mult/index_counter.sv
matrix_mult/modular_multiplier.sv
hw/ntm_matrix_mult_top.sv
bench/ntm_matrix_mult_chk.sv
bench/tb_ntm_matrix_mult.sv

// File: Makefile
TOP := tb_ntm_matrix_mult
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench, log in $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -f tb.f
	@./obj_dir/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
